//--- common/bpu_pkg.sv
package bpu_pkg;

    ////////////////////
    // widths
    ////////////////////

    // one word for pcs, targets and instructions
    localparam int ADDR_WIDTH = 32;
    localparam int INST_WIDTH = 32;

    // major opcode sits in the top six bits of an instruction
    localparam int OPCODE_WIDTH = 6;

    // first fetch group after reset, aligned to the 8-byte group
    localparam logic [ADDR_WIDTH-1:0] RESET_PC = 32'h1c00_0000;

    ////////////////////
    // encodings
    ////////////////////

    // major opcodes treated as branches or jumps
    typedef enum logic [OPCODE_WIDTH-1:0] {
        op_bceqz = 6'b010010,
        op_jirl  = 6'b010011,
        op_b     = 6'b010100,
        op_bl    = 6'b010101,
        op_beq   = 6'b010110,
        op_bne   = 6'b010111,
        op_blt   = 6'b011000,
        op_bge   = 6'b011001,
        op_bltu  = 6'b011010,
        op_bgeu  = 6'b011011
    } branch_op_e;

    // 2-bit direction counter, upper bit set means predict taken
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_e;

endpackage

//--- bpu/branch_predecode.sv
`timescale 1ns/1ns

module branch_predecode
    import bpu_pkg::*;
(
    input  logic [INST_WIDTH-1:0] inst_1,
    input  logic [INST_WIDTH-1:0] inst_2,
    output logic                  is_branch_1,
    output logic                  is_branch_2
);

    // one classifier shared by both slots
    function automatic logic is_branch_op(input logic [INST_WIDTH-1:0] inst);
        branch_op_e op;
        op = branch_op_e'(inst[INST_WIDTH-1 -: OPCODE_WIDTH]);
        unique case (op)
            op_bceqz,
            op_jirl,
            op_b,
            op_bl,
            op_beq,
            op_bne,
            op_blt,
            op_bge,
            op_bltu,
            op_bgeu: begin
                is_branch_op = 1'b1;
            end
            default: begin
                is_branch_op = 1'b0;
            end
        endcase
    endfunction

    ////////////////////
    // per-slot flags
    ////////////////////

    always_comb begin
        is_branch_1 = is_branch_op(inst_1);
        is_branch_2 = is_branch_op(inst_2);
    end

endmodule

//--- bpu/bht.sv
`timescale 1ns/1ns

module bht
    import bpu_pkg::*;
#(
    parameter int BHT_INDEX_BITS = 6
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] pc_1,
    input  logic [ADDR_WIDTH-1:0] pc_2,
    input  logic                  update_en,
    input  logic [ADDR_WIDTH-1:0] update_pc,
    input  logic                  update_taken,
    output logic                  taken_1,
    output logic                  taken_2
);

    localparam int ENTRIES = 2 ** BHT_INDEX_BITS;

    counter_e counters [ENTRIES];

    logic [BHT_INDEX_BITS-1:0] rd_idx_1;
    logic [BHT_INDEX_BITS-1:0] rd_idx_2;
    logic [BHT_INDEX_BITS-1:0] wr_idx;

    // word index, so neighbouring slots hit neighbouring counters
    assign rd_idx_1 = pc_1[BHT_INDEX_BITS+1:2];
    assign rd_idx_2 = pc_2[BHT_INDEX_BITS+1:2];
    assign wr_idx   = update_pc[BHT_INDEX_BITS+1:2];

    // one step toward the resolved direction, held at the strong ends
    function automatic counter_e step(input counter_e cur, input logic taken);
        case (cur)
            strong_not_taken: step = taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   step = taken ? weak_taken : strong_not_taken;
            weak_taken:       step = taken ? strong_taken : weak_not_taken;
            default:          step = taken ? strong_taken : weak_taken;
        endcase
    endfunction

    ////////////////////
    // read ports
    ////////////////////

    assign taken_1 = counters[rd_idx_1][1];
    assign taken_2 = counters[rd_idx_2][1];

    ////////////////////
    // training
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= weak_not_taken;
            end
        end else if (update_en) begin
            counters[wr_idx] <= step(counters[wr_idx], update_taken);
        end
    end

    // an unknown index would corrupt an arbitrary counter
    a_update_pc_known: assert property (
        @(posedge clk) disable iff (reset) update_en |-> !$isunknown(update_pc)
    );

endmodule

//--- bpu/btb.sv
`timescale 1ns/1ns

module btb
    import bpu_pkg::*;
#(
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] pc_1,
    input  logic [ADDR_WIDTH-1:0] pc_2,
    input  logic                  update_en,
    input  logic [ADDR_WIDTH-1:0] update_pc,
    input  logic                  update_taken,
    input  logic [ADDR_WIDTH-1:0] update_target,
    output logic                  hit_1,
    output logic                  hit_2,
    output logic [ADDR_WIDTH-1:0] target_1,
    output logic [ADDR_WIDTH-1:0] target_2
);

    localparam int ENTRIES  = 2 ** BTB_INDEX_BITS;
    localparam int TAG_BITS = ADDR_WIDTH - BTB_INDEX_BITS - 2;

    logic                  valid   [ENTRIES];
    logic [TAG_BITS-1:0]   tags    [ENTRIES];
    logic [ADDR_WIDTH-1:0] targets [ENTRIES];

    logic [BTB_INDEX_BITS-1:0] rd_idx_1;
    logic [BTB_INDEX_BITS-1:0] rd_idx_2;
    logic [BTB_INDEX_BITS-1:0] wr_idx;
    logic                      wr_en;

    assign rd_idx_1 = pc_1[BTB_INDEX_BITS+1:2];
    assign rd_idx_2 = pc_2[BTB_INDEX_BITS+1:2];
    assign wr_idx   = update_pc[BTB_INDEX_BITS+1:2];

    // only taken branches allocate, not-taken ones keep the old target
    assign wr_en = update_en && update_taken;

    ////////////////////
    // lookup
    ////////////////////

    assign hit_1    = valid[rd_idx_1] && (tags[rd_idx_1] == pc_1[ADDR_WIDTH-1 -: TAG_BITS]);
    assign hit_2    = valid[rd_idx_2] && (tags[rd_idx_2] == pc_2[ADDR_WIDTH-1 -: TAG_BITS]);
    assign target_1 = targets[rd_idx_1];
    assign target_2 = targets[rd_idx_2];

    ////////////////////
    // fill
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_idx]    <= update_pc[ADDR_WIDTH-1 -: TAG_BITS];
            targets[wr_idx] <= update_target;
        end
    end

    // a misaligned target would later steer fetch off the word grid
    a_target_aligned: assert property (
        @(posedge clk) disable iff (reset) wr_en |-> (update_target[1:0] == 2'b00)
    );

endmodule

//--- bpu/bpu.sv
`timescale 1ns/1ns

module bpu
    import bpu_pkg::*;
#(
    parameter int BHT_INDEX_BITS = 6,
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic [ADDR_WIDTH-1:0] pc,
    input  logic [INST_WIDTH-1:0] inst_1,
    input  logic [INST_WIDTH-1:0] inst_2,
    input  logic                  inst_en_1,
    input  logic                  inst_en_2,
    input  logic                  update_en,
    input  logic [ADDR_WIDTH-1:0] update_pc,
    input  logic                  update_taken,
    input  logic [ADDR_WIDTH-1:0] update_target,
    output logic                  is_branch_1,
    output logic                  is_branch_2,
    output logic                  pred_taken,
    output logic [ADDR_WIDTH-1:0] pred_target,
    output logic                  fetch_1_en,
    output logic                  fetch_2_en
);

    logic [ADDR_WIDTH-1:0] pc_2;
    logic                  dir_taken_1;
    logic                  dir_taken_2;
    logic                  hit_1;
    logic                  hit_2;
    logic [ADDR_WIDTH-1:0] target_1;
    logic [ADDR_WIDTH-1:0] target_2;
    logic                  slot_taken_1;
    logic                  slot_taken_2;

    // second instruction of the group
    assign pc_2 = pc + ADDR_WIDTH'(4);

    branch_predecode u_predecode (
        .inst_1      (inst_1),
        .inst_2      (inst_2),
        .is_branch_1 (is_branch_1),
        .is_branch_2 (is_branch_2)
    );

    bht #(
        .BHT_INDEX_BITS (BHT_INDEX_BITS)
    ) u_bht (
        .clk          (clk),
        .reset        (reset),
        .pc_1         (pc),
        .pc_2         (pc_2),
        .update_en    (update_en),
        .update_pc    (update_pc),
        .update_taken (update_taken),
        .taken_1      (dir_taken_1),
        .taken_2      (dir_taken_2)
    );

    btb #(
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) u_btb (
        .clk           (clk),
        .reset         (reset),
        .pc_1          (pc),
        .pc_2          (pc_2),
        .update_en     (update_en),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target),
        .hit_1         (hit_1),
        .hit_2         (hit_2),
        .target_1      (target_1),
        .target_2      (target_2)
    );

    ////////////////////
    // slot selection
    ////////////////////

    // taken needs a live branch, a taken counter and a btb hit
    assign slot_taken_1 = is_branch_1 && inst_en_1 && dir_taken_1 && hit_1;
    assign slot_taken_2 = is_branch_2 && inst_en_2 && dir_taken_2 && hit_2;

    assign pred_taken = slot_taken_1 || slot_taken_2;

    // slot 1 wins when both are taken
    always_comb begin
        if (slot_taken_1) begin
            pred_target = target_1;
        end else if (slot_taken_2) begin
            pred_target = target_2;
        end else begin
            pred_target = '0;
        end
    end

    // nothing is kept while the group is being discarded or held
    always_comb begin
        if (reset || stall || flush) begin
            fetch_1_en = 1'b0;
            fetch_2_en = 1'b0;
        end else begin
            fetch_1_en = 1'b1;
            fetch_2_en = !slot_taken_1;
        end
    end

endmodule

//--- source/fetch_pc.sv
`timescale 1ns/1ns

module fetch_pc
    import bpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic [ADDR_WIDTH-1:0] flush_target,
    input  logic                  pred_taken,
    input  logic [ADDR_WIDTH-1:0] pred_target,
    output logic [ADDR_WIDTH-1:0] pc
);

    logic [ADDR_WIDTH-1:0] next_pc;

    ////////////////////
    // next pc
    ////////////////////

    // flush beats stall, stall beats prediction
    always_comb begin
        if (flush) begin
            next_pc = flush_target;
        end else if (stall) begin
            next_pc = pc;
        end else if (pred_taken) begin
            next_pc = pred_target;
        end else begin
            next_pc = pc + ADDR_WIDTH'(8);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // flush and btb targets are word aligned, so fetch never drifts off
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
    );

endmodule

//--- source/fetch_predict_top.sv
`timescale 1ns/1ns

module fetch_predict_top
    import bpu_pkg::*;
#(
    parameter int BHT_INDEX_BITS = 6,
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic [ADDR_WIDTH-1:0] flush_target,
    input  logic [INST_WIDTH-1:0] inst_1,
    input  logic [INST_WIDTH-1:0] inst_2,
    input  logic                  inst_en_1,
    input  logic                  inst_en_2,
    input  logic                  update_en,
    input  logic [ADDR_WIDTH-1:0] update_pc,
    input  logic                  update_taken,
    input  logic [ADDR_WIDTH-1:0] update_target,
    output logic [ADDR_WIDTH-1:0] fetch_pc,
    output logic                  is_branch_1,
    output logic                  is_branch_2,
    output logic                  pred_taken,
    output logic [ADDR_WIDTH-1:0] pred_target,
    output logic                  fetch_1_en,
    output logic                  fetch_2_en
);

    fetch_pc u_fetch_pc (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .flush        (flush),
        .flush_target (flush_target),
        .pred_taken   (pred_taken),
        .pred_target  (pred_target),
        .pc           (fetch_pc)
    );

    bpu #(
        .BHT_INDEX_BITS (BHT_INDEX_BITS),
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) u_bpu (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .flush         (flush),
        .pc            (fetch_pc),
        .inst_1        (inst_1),
        .inst_2        (inst_2),
        .inst_en_1     (inst_en_1),
        .inst_en_2     (inst_en_2),
        .update_en     (update_en),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target),
        .is_branch_1   (is_branch_1),
        .is_branch_2   (is_branch_2),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target),
        .fetch_1_en    (fetch_1_en),
        .fetch_2_en    (fetch_2_en)
    );

endmodule

//--- verif/fetch_predict_model.svh
`ifndef FETCH_PREDICT_MODEL_SVH
`define FETCH_PREDICT_MODEL_SVH

// reference copies of the direction counters and the btb
logic [1:0]  ref_ctr    [2 ** BHT_BITS];
logic        ref_valid  [2 ** BTB_BITS];
logic [31:0] ref_tag    [2 ** BTB_BITS];
logic [31:0] ref_target [2 ** BTB_BITS];
logic [31:0] ref_pc;

// every major opcode from 010010 up to 011011
function automatic logic opcode_is_branch(input logic [31:0] inst);
    return (inst[31:26] >= 6'b010010) && (inst[31:26] <= 6'b011011);
endfunction

// word address modulo table size
function automatic int bht_slot(input logic [31:0] pc);
    return int'((pc >> 2) % (2 ** BHT_BITS));
endfunction

function automatic int btb_slot(input logic [31:0] pc);
    return int'((pc >> 2) % (2 ** BTB_BITS));
endfunction

function automatic logic [31:0] tag_of(input logic [31:0] pc);
    return pc >> (BTB_BITS + 2);
endfunction

// branch, live slot, taken counter and a matching btb entry
function automatic logic slot_taken(input logic [31:0] pc, input logic [31:0] inst,
                                    input logic en);
    int  b;
    int  t;
    logic dir;
    b   = bht_slot(pc);
    t   = btb_slot(pc);
    dir = (ref_ctr[b] == weak_taken) || (ref_ctr[b] == strong_taken);
    return opcode_is_branch(inst) && en && dir && ref_valid[t] && (ref_tag[t] == tag_of(pc));
endfunction

task automatic clear_tables();
    for (int i = 0; i < 2 ** BHT_BITS; i++) begin
        ref_ctr[i] = weak_not_taken;
    end
    for (int i = 0; i < 2 ** BTB_BITS; i++) begin
        ref_valid[i] = 1'b0;
    end
endtask

// counter steps one state, btb only fills on taken
task automatic train_tables(input logic [31:0] pc, input logic taken,
                            input logic [31:0] target);
    int b;
    int t;
    b = bht_slot(pc);
    t = btb_slot(pc);
    if (taken && ref_ctr[b] != strong_taken) begin
        ref_ctr[b] = ref_ctr[b] + 2'd1;
    end else if (!taken && ref_ctr[b] != strong_not_taken) begin
        ref_ctr[b] = ref_ctr[b] - 2'd1;
    end
    if (taken) begin
        ref_valid[t]  = 1'b1;
        ref_tag[t]    = tag_of(pc);
        ref_target[t] = target;
    end
endtask

`endif

//--- verif/tb_fetch_predict.sv
`timescale 1ns/1ns

module tb_fetch_predict
    import bpu_pkg::*;
();

    localparam int BHT_BITS       = 6;
    localparam int BTB_BITS       = 4;
    localparam int RESET_CYCLES   = 3;
    localparam int N_CYCLES       = 2000;
    localparam int TIMEOUT_CYCLES = N_CYCLES + 100;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        flush;
    logic [31:0] flush_target;
    logic [31:0] inst_1;
    logic [31:0] inst_2;
    logic        inst_en_1;
    logic        inst_en_2;
    logic        update_en;
    logic [31:0] update_pc;
    logic        update_taken;
    logic [31:0] update_target;
    logic [31:0] fetch_pc;
    logic        is_branch_1;
    logic        is_branch_2;
    logic        pred_taken;
    logic [31:0] pred_target;
    logic        fetch_1_en;
    logic        fetch_2_en;

    integer seed;
    int     cycle_count = 0;
    int     slot_1_taken_seen = 0;
    int     slot_2_only_seen = 0;

    `include "fetch_predict_model.svh"

    fetch_predict_top #(
        .BHT_INDEX_BITS (BHT_BITS),
        .BTB_INDEX_BITS (BTB_BITS)
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .flush         (flush),
        .flush_target  (flush_target),
        .inst_1        (inst_1),
        .inst_2        (inst_2),
        .inst_en_1     (inst_en_1),
        .inst_en_2     (inst_en_2),
        .update_en     (update_en),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target),
        .fetch_pc      (fetch_pc),
        .is_branch_1   (is_branch_1),
        .is_branch_2   (is_branch_2),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target),
        .fetch_1_en    (fetch_1_en),
        .fetch_2_en    (fetch_2_en)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    ////////////////////
    // stimulus
    ////////////////////

    // small pc pools keep retraining the same entries
    task automatic drive_inputs();
        logic [31:0] i1;
        logic [31:0] i2;
        i1 = $random(seed);
        i2 = $random(seed);
        if (rand_below(2) == 0) begin
            i1[31:26] = 6'(32'h12 + rand_below(10));
        end
        if (rand_below(2) == 0) begin
            i2[31:26] = 6'(32'h12 + rand_below(10));
        end
        inst_1        <= i1;
        inst_2        <= i2;
        inst_en_1     <= rand_below(8) != 0;
        inst_en_2     <= rand_below(8) != 0;
        stall         <= rand_below(8) == 0;
        flush         <= rand_below(16) == 0;
        flush_target  <= RESET_PC + 8 * rand_below(16);
        update_en     <= rand_below(2) == 0;
        update_pc     <= RESET_PC + 4 * rand_below(32);
        update_taken  <= rand_below(4) != 0;
        update_target <= RESET_PC + 8 * rand_below(16);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %0t ns %s is %h, expected %h", $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    ////////////////////
    // checks
    ////////////////////

    always @(negedge clk) begin : check_cycle
        logic        s1;
        logic        s2;
        logic        idle;
        logic [31:0] exp_target;
        s1   = slot_taken(ref_pc, inst_1, inst_en_1);
        s2   = slot_taken(ref_pc + 4, inst_2, inst_en_2);
        idle = reset || stall || flush;
        // slot 1 wins over slot 2
        if (s1) begin
            exp_target = ref_target[btb_slot(ref_pc)];
        end else if (s2) begin
            exp_target = ref_target[btb_slot(ref_pc + 4)];
        end else begin
            exp_target = 32'h0;
        end
        check_value("fetch_pc", fetch_pc, ref_pc);
        check_value("is_branch_1", is_branch_1, opcode_is_branch(inst_1));
        check_value("is_branch_2", is_branch_2, opcode_is_branch(inst_2));
        check_value("pred_taken", pred_taken, s1 || s2);
        check_value("pred_target", pred_target, exp_target);
        check_value("fetch_1_en", fetch_1_en, !idle);
        check_value("fetch_2_en", fetch_2_en, !idle && !s1);
        if (!idle && s1) begin
            slot_1_taken_seen++;
        end
        if (!idle && s2 && !s1) begin
            slot_2_only_seen++;
        end
        // state loaded at the coming rising edge
        if (reset) begin
            clear_tables();
            ref_pc = RESET_PC;
        end else begin
            if (update_en) begin
                train_tables(update_pc, update_taken, update_target);
            end
            if (flush) begin
                ref_pc = flush_target;
            end else if (stall) begin
                ref_pc = ref_pc;
            end else if (s1 || s2) begin
                ref_pc = exp_target;
            end else begin
                ref_pc = ref_pc + 32'd8;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $fatal(1);
        end
    end

    initial begin
        seed          = 32'hffb9_ab84;
        reset         = 1'b1;
        stall         = 1'b0;
        flush         = 1'b0;
        flush_target  = RESET_PC;
        inst_1        = 32'h0;
        inst_2        = 32'h0;
        inst_en_1     = 1'b0;
        inst_en_2     = 1'b0;
        update_en     = 1'b0;
        update_pc     = RESET_PC;
        update_taken  = 1'b0;
        update_target = RESET_PC;
        ref_pc        = RESET_PC;
        clear_tables();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < N_CYCLES; i++) begin
            drive_inputs();
            @(posedge clk);
        end
        if (slot_1_taken_seen > 0 && slot_2_only_seen > 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("The run never predicted a taken slot 1 and a lone taken slot 2");
            $display("Result: FAILED");
            $fatal(1);
        end
    end

endmodule

//--- flist.f
+incdir+verif
common/bpu_pkg.sv
bpu/branch_predecode.sv
bpu/bht.sv
bpu/btb.sv
bpu/bpu.sv
source/fetch_pc.sv
source/fetch_predict_top.sv
verif/tb_fetch_predict.sv
